// File: rtl/turboPkg.sv
package turboPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map, byte offsets on the APB side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [12:0] TURBO_CONTROL        = 13'h000;
    localparam logic [12:0] TURBO_INVERSE_MEAN   = 13'h004;
    localparam logic [12:0] TURBO_OUTPUT_CLK_DIV = 13'h008;
    localparam logic [12:0] TURBO_DAC_SELECT     = 13'h00C;
    localparam logic [12:0] TURBO_ASM_PARMS      = 13'h010;
    localparam logic [12:0] ADDR_LAST            = TURBO_ASM_PARMS;

    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        VERIFY = 2'd1,
        LOCKED = 2'd2
    } lockModeE;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [12:0] paddr;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apbReqS;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apbRspS;

    // One register access per APB transfer; byteEn is zero on reads.
    typedef struct packed {
        logic        access;
        logic [12:0] addr;
        logic [3:0]  byteEn;
        logic [31:0] writeData;
    } regAccessS;

    typedef struct packed {
        logic [2:0]  codeRate;
        logic [2:0]  codeLength;
        logic [3:0]  maxIterations;
        logic [15:0] inverseMeanMantissa;
        logic [2:0]  inverseMeanExponent;
        logic [15:0] outputEnClkDiv;
        logic [3:0]  dac0Select;
        logic [3:0]  dac1Select;
        logic [3:0]  dac2Select;
        logic [31:0] asmParms;
    } turboConfigS;

    typedef struct packed {
        lockModeE lockMode;
        logic     overflow;
    } statusS;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit layouts of the 32-bit registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [12:0] reserved31;
        lockModeE    lockMode;      // Live status, read only.
        logic        overflow;      // Sticky, read only.
        logic [2:0]  reserved13;
        logic        overflowClear; // Write one to clear, reads zero.
        logic [3:0]  maxIterations;
        logic        reserved7;
        logic [2:0]  codeLength;
        logic        reserved3;
        logic [2:0]  codeRate;
    } controlWordS;

    typedef struct packed {
        logic [12:0] reserved19;
        logic [2:0]  exponent;
        logic [15:0] mantissa;
    } inverseMeanWordS;

    typedef struct packed {
        logic [11:0] reserved20;
        logic [3:0]  dac2Select;
        logic [3:0]  reserved12;
        logic [3:0]  dac1Select;
        logic [3:0]  reserved4;
        logic [3:0]  dac0Select;
    } dacSelectWordS;

    typedef union packed {
        logic [31:0]     word;
        controlWordS     control;
        inverseMeanWordS inverseMean;
        dacSelectWordS   dacSelect;
    } regWordU;

endpackage

// File: rtl/apbTurboSlave.sv
`timescale 1ns/1ps

module apbTurboSlave (
    input  logic                 busClk,
    input  logic                 reset,
    input  turboPkg::apbReqS     apbReq,
    input  logic [31:0]          readData,
    output turboPkg::apbRspS     apbRsp,
    output turboPkg::regAccessS  regAccess
);

    logic setupSeen;
    logic accessCycle;
    logic addrBad;

    // Remembers that the previous cycle was a setup cycle.
    always_ff @(posedge busClk) begin
        if (reset) begin
            setupSeen <= 1'b0;
        end else begin
            setupSeen <= apbReq.psel && !apbReq.penable;
        end
    end

    assign accessCycle = apbReq.psel && apbReq.penable && setupSeen;
    assign addrBad     = (apbReq.paddr > turboPkg::ADDR_LAST) ||
                         (apbReq.paddr[1:0] != 2'b00);

    // No wait states, every access cycle completes.
    assign apbRsp.pready  = 1'b1;
    assign apbRsp.pslverr = accessCycle && addrBad;
    assign apbRsp.prdata  = (accessCycle && !addrBad && !apbReq.pwrite) ? readData : 32'h0;

    assign regAccess.access    = accessCycle && !addrBad;
    assign regAccess.addr      = apbReq.paddr;
    assign regAccess.byteEn    = apbReq.pwrite ? apbReq.pstrb : 4'b0000;
    assign regAccess.writeData = apbReq.pwdata;

    penableNeedsPsel: assert property (
        @(posedge busClk) disable iff (reset)
        apbReq.penable |-> apbReq.psel
    );

endmodule

// File: rtl/turboRegs.sv
`timescale 1ns/1ps

module turboRegs (
    input  logic                   busClk,
    input  logic                   reset,
    input  turboPkg::regAccessS    regAccess,
    input  turboPkg::statusS       status,
    output logic [31:0]            readData,
    output turboPkg::turboConfigS  turboConfig,
    output logic                   overflowClear
);

    logic          selControl;
    logic          selInverseMean;
    logic          selClkDiv;
    logic          selDacSelect;
    logic          selAsmParms;
    logic [3:0]    we;
    turboPkg::regWordU wr;
    turboPkg::regWordU rd;

    assign selControl     = regAccess.access && (regAccess.addr == turboPkg::TURBO_CONTROL);
    assign selInverseMean = regAccess.access && (regAccess.addr == turboPkg::TURBO_INVERSE_MEAN);
    assign selClkDiv      = regAccess.access && (regAccess.addr == turboPkg::TURBO_OUTPUT_CLK_DIV);
    assign selDacSelect   = regAccess.access && (regAccess.addr == turboPkg::TURBO_DAC_SELECT);
    assign selAsmParms    = regAccess.access && (regAccess.addr == turboPkg::TURBO_ASM_PARMS);

    assign we      = regAccess.byteEn;
    assign wr.word = regAccess.writeData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte-laned writes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge busClk) begin
        if (reset) begin
            turboConfig   <= '0;
            overflowClear <= 1'b0;
        end else begin
            overflowClear <= selControl && we[1] && wr.control.overflowClear;

            if (we[0]) begin
                if (selControl) begin
                    turboConfig.codeRate   <= wr.control.codeRate;
                    turboConfig.codeLength <= wr.control.codeLength;
                end
                if (selInverseMean) begin
                    turboConfig.inverseMeanMantissa[7:0] <= wr.inverseMean.mantissa[7:0];
                end
                if (selClkDiv) begin
                    turboConfig.outputEnClkDiv[7:0] <= wr.word[7:0];
                end
                if (selDacSelect) begin
                    turboConfig.dac0Select <= wr.dacSelect.dac0Select;
                end
            end

            if (we[1]) begin
                if (selControl) begin
                    turboConfig.maxIterations <= wr.control.maxIterations;
                end
                if (selInverseMean) begin
                    turboConfig.inverseMeanMantissa[15:8] <= wr.inverseMean.mantissa[15:8];
                end
                if (selClkDiv) begin
                    turboConfig.outputEnClkDiv[15:8] <= wr.word[15:8];
                end
                if (selDacSelect) begin
                    turboConfig.dac1Select <= wr.dacSelect.dac1Select;
                end
            end

            if (we[2]) begin
                if (selInverseMean) begin
                    turboConfig.inverseMeanExponent <= wr.inverseMean.exponent;
                end
                if (selDacSelect) begin
                    turboConfig.dac2Select <= wr.dacSelect.dac2Select;
                end
            end

            // The marker is the only register that spans all four lanes.
            for (int lane = 0; lane < 4; lane++) begin
                if (we[lane] && selAsmParms) begin
                    turboConfig.asmParms[8*lane +: 8] <= wr.word[8*lane +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Readback is combinational on the address.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd.word = 32'h0;
        case (regAccess.addr)
            turboPkg::TURBO_CONTROL: begin
                rd.control.codeRate      = turboConfig.codeRate;
                rd.control.codeLength    = turboConfig.codeLength;
                rd.control.maxIterations = turboConfig.maxIterations;
                rd.control.overflow      = status.overflow;
                rd.control.lockMode      = status.lockMode;
            end
            turboPkg::TURBO_INVERSE_MEAN: begin
                rd.inverseMean.mantissa = turboConfig.inverseMeanMantissa;
                rd.inverseMean.exponent = turboConfig.inverseMeanExponent;
            end
            turboPkg::TURBO_OUTPUT_CLK_DIV: rd.word[15:0] = turboConfig.outputEnClkDiv;
            turboPkg::TURBO_DAC_SELECT: begin
                rd.dacSelect.dac0Select = turboConfig.dac0Select;
                rd.dacSelect.dac1Select = turboConfig.dac1Select;
                rd.dacSelect.dac2Select = turboConfig.dac2Select;
            end
            turboPkg::TURBO_ASM_PARMS: rd.word = turboConfig.asmParms;
            default: rd.word = 32'h0;
        endcase
    end

    assign readData = rd.word;

    // A granted access always lands on exactly one register.
    oneSelectAtATime: assert property (
        @(posedge busClk) disable iff (reset)
        regAccess.access |-> $onehot({selControl, selInverseMean, selClkDiv, selDacSelect,
                                      selAsmParms})
    );

endmodule

// File: rtl/asmSyncDetector.sv
`timescale 1ns/1ps

module asmSyncDetector #(
    parameter int FRAME_BITS = 256
) (
    input  logic                busClk,
    input  logic                reset,
    input  logic                bitIn,
    input  logic                bitValid,
    input  logic [31:0]         asmParms,
    output turboPkg::lockModeE  lockMode,
    output logic                lockedBit,
    output logic                lockedValid
);

    localparam int POS_W = $clog2(FRAME_BITS);

    logic [31:0]      window;
    logic [31:0]      asmPrev;
    logic             checkNow;     // Window holds a fresh bit this cycle.
    logic [POS_W-1:0] framePos;
    logic             missOnce;
    logic             match;
    logic             frameEnd;

    assign match    = (window == asmParms);
    assign frameEnd = (framePos == POS_W'(FRAME_BITS - 1));

    always_ff @(posedge busClk) begin
        if (reset) begin
            window   <= '0;
            checkNow <= 1'b0;
            asmPrev  <= '0;
        end else begin
            checkNow <= bitValid;
            asmPrev  <= asmParms;
            if (bitValid) begin
                window <= {window[30:0], bitIn};
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Search, verify and lock.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge busClk) begin
        if (reset) begin
            lockMode <= turboPkg::SEARCH;
            framePos <= '0;
            missOnce <= 1'b0;
        end else if (asmParms != asmPrev) begin
            lockMode <= turboPkg::SEARCH;   // New marker, start over.
            framePos <= '0;
            missOnce <= 1'b0;
        end else if (checkNow) begin
            framePos <= frameEnd ? '0 : framePos + 1'b1;
            case (lockMode)
                turboPkg::SEARCH: begin
                    if (match) begin
                        lockMode <= turboPkg::VERIFY;
                        framePos <= '0;
                    end
                end
                turboPkg::VERIFY: begin
                    missOnce <= 1'b0;
                    if (frameEnd) begin
                        lockMode <= match ? turboPkg::LOCKED : turboPkg::SEARCH;
                    end
                end
                turboPkg::LOCKED: begin
                    if (frameEnd) begin
                        if (match) begin
                            missOnce <= 1'b0;
                        end else if (missOnce) begin
                            lockMode <= turboPkg::SEARCH;   // Second miss in a row.
                        end else begin
                            missOnce <= 1'b1;
                        end
                    end
                end
                default: lockMode <= turboPkg::SEARCH;
            endcase
        end
    end

    always_ff @(posedge busClk) begin
        lockedBit <= bitIn;
    end

    always_ff @(posedge busClk) begin
        if (reset) begin
            lockedValid <= 1'b0;
        end else begin
            lockedValid <= bitValid && (lockMode == turboPkg::LOCKED);
        end
    end

    noUnusedMode: assert property (
        @(posedge busClk) disable iff (reset)
        lockMode != 2'b11
    );

endmodule

// File: rtl/outputBitPacer.sv
`timescale 1ns/1ps

module outputBitPacer #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        busClk,
    input  logic        reset,
    input  logic        lockedBit,
    input  logic        lockedValid,
    input  logic [15:0] outputEnClkDiv,
    input  logic        overflowClear,
    output logic        bitOut,
    output logic        outputEn,
    output logic        overflow
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [15:0]      divCount;
    logic             fire;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;
    logic             fifoMem [FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fire  = (divCount == 16'd0);
    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign push  = lockedValid && !full;   // A bit arriving while full is lost.
    assign pop   = fire && !empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobe divider, one pulse every outputEnClkDiv plus 1 cycles.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge busClk) begin
        if (reset) begin
            divCount <= 16'd0;
            outputEn <= 1'b0;
            bitOut   <= 1'b0;
        end else begin
            outputEn <= fire;
            bitOut   <= pop ? fifoMem[rdPtr] : 1'b0;
            divCount <= fire ? outputEnClkDiv : divCount - 1'b1;
        end
    end

    always_ff @(posedge busClk) begin
        if (reset) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (overflowClear) begin
                overflow <= 1'b0;
            end else if (lockedValid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (push) fifoMem[wrPtr] <= lockedBit;
    end

    countInRange: assert property (
        @(posedge busClk) disable iff (reset)
        count <= CNT_W'(FIFO_DEPTH)
    );

    // Back-to-back strobes come only from a divider of zero loaded two cycles earlier.
    strobeSpacing: assert property (
        @(posedge busClk) disable iff (reset)
        (outputEn && $past(outputEn)) |-> ($past(outputEnClkDiv, 2) == 16'd0)
    );

endmodule

// File: rtl/turboCtrlTop.sv
`timescale 1ns/1ps

module turboCtrlTop #(
    parameter int FRAME_BITS = 256,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   busClk,
    input  logic                   reset,
    input  turboPkg::apbReqS       apbReq,
    output turboPkg::apbRspS       apbRsp,
    input  logic                   bitIn,
    input  logic                   bitValid,
    output logic                   bitOut,
    output logic                   outputEn,
    output turboPkg::turboConfigS  turboConfig
);

    turboPkg::regAccessS regAccess;
    turboPkg::statusS    status;
    turboPkg::lockModeE  lockMode;
    logic [31:0]         readData;
    logic                overflow;
    logic                overflowClear;
    logic                lockedBit;
    logic                lockedValid;

    assign status = '{lockMode: lockMode, overflow: overflow};

    apbTurboSlave slave_i (
        .busClk    (busClk),
        .reset     (reset),
        .apbReq    (apbReq),
        .readData  (readData),
        .apbRsp    (apbRsp),
        .regAccess (regAccess)
    );

    turboRegs regs_i (
        .busClk        (busClk),
        .reset         (reset),
        .regAccess     (regAccess),
        .status        (status),
        .readData      (readData),
        .turboConfig   (turboConfig),
        .overflowClear (overflowClear)
    );

    asmSyncDetector #(.FRAME_BITS(FRAME_BITS)) sync_i (
        .busClk      (busClk),
        .reset       (reset),
        .bitIn       (bitIn),
        .bitValid    (bitValid),
        .asmParms    (turboConfig.asmParms),
        .lockMode    (lockMode),
        .lockedBit   (lockedBit),
        .lockedValid (lockedValid)
    );

    outputBitPacer #(.FIFO_DEPTH(FIFO_DEPTH)) pacer_i (
        .busClk         (busClk),
        .reset          (reset),
        .lockedBit      (lockedBit),
        .lockedValid    (lockedValid),
        .outputEnClkDiv (turboConfig.outputEnClkDiv),
        .overflowClear  (overflowClear),
        .bitOut         (bitOut),
        .outputEn       (outputEn),
        .overflow       (overflow)
    );

endmodule

// File: bench/turboCtrlTb.sv
`timescale 1ns/1ps

module turboCtrlTb;

    localparam int  FRAME_BITS = 256;
    localparam real CLK_PERIOD = 100.0;
    localparam int  SYNC_LIMIT = 300;   // Cycles allowed to find an outputEn pulse.
    localparam int  MARGIN     = 100;

    logic                  busClk;
    logic                  reset;
    turboPkg::apbReqS      apbReq;
    turboPkg::apbRspS      apbRsp;
    logic                  bitIn;
    logic                  bitValid;
    logic                  bitOut;
    logic                  outputEn;
    turboPkg::turboConfigS turboConfig;

    int                 cycleNo;
    int                 checksPassed;
    int                 checksFailed;
    int                 testErrors;
    int                 testsPassed;
    int                 testsFailed;
    string              testName;
    string              lines[$];
    logic [31:0]        lfsr;
    turboPkg::lockModeE modelMode;      // Expected detector state at frame level.
    logic               modelMiss;
    int                 dueQ[$];        // Cycle in which each locked bit leaves the pacer.
    logic               expBitQ[$];

    turboCtrlTop dut_i (
        .busClk      (busClk),
        .reset       (reset),
        .apbReq      (apbReq),
        .apbRsp      (apbRsp),
        .bitIn       (bitIn),
        .bitValid    (bitValid),
        .bitOut      (bitOut),
        .outputEn    (outputEn),
        .turboConfig (turboConfig)
    );

    always #(CLK_PERIOD / 2) busClk = ~busClk;

    always @(posedge busClk) begin
        cycleNo <= cycleNo + 1;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1. The payload bit is state[0].
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic noteResult(input logic ok);
        if (ok) begin
            checksPassed++;
        end else begin
            checksFailed++;
            testErrors++;
        end
    endtask

    task automatic checkWord(input string name, input turboPkg::regWordU got,
                             input turboPkg::regWordU exp);
        if (got.word !== exp.word) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got.word, exp.word);
        end
        noteResult(got.word === exp.word);
    endtask

    task automatic checkLock(input turboPkg::lockModeE got, input turboPkg::lockModeE exp);
        if (got !== exp) begin
            $display("[ERROR] %0t lockMode got %s expected %s", $time, got.name(), exp.name());
        end
        noteResult(got === exp);
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
        noteResult(got === exp);
    endtask

    task automatic checkConfig(input turboPkg::turboConfigS got,
                               input turboPkg::turboConfigS exp);
        if (got !== exp) begin
            $display("[ERROR] %0t turboConfig got %h expected %h", $time, got, exp);
        end
        noteResult(got === exp);
    endtask

    task automatic checkErr(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t pslverr got %b expected %b", $time, got, exp);
        end
        noteResult(got === exp);
    endtask

    // Every monitored locked bit must appear with an outputEn pulse in its due cycle.
    always @(negedge busClk) begin
        if (dueQ.size() != 0 && dueQ[0] == cycleNo) begin
            checkBit("outputEn", outputEn, 1'b1);
            checkBit("bitOut", bitOut, expBitQ[0]);
            void'(dueQ.pop_front());
            void'(expBitQ.pop_front());
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus and stream drivers. Each starts and ends 2 ns after a rising edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apbTransfer(input logic write, input logic [12:0] addr,
                               input logic [31:0] data, input logic [3:0] strb,
                               output logic [31:0] rdata, output logic err);
        apbReq.psel    = 1'b1;          // Setup cycle.
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = data;
        apbReq.pstrb   = write ? strb : 4'h0;
        @(posedge busClk);
        #2;
        apbReq.penable = 1'b1;          // Access cycle.
        @(negedge busClk);
        checkBit("pready", apbRsp.pready, 1'b1);
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(posedge busClk);
        #2;
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic readControl(output turboPkg::regWordU word);
        logic [31:0] raw;
        logic        err;
        apbTransfer(1'b0, turboPkg::TURBO_CONTROL, 32'h0, 4'h0, raw, err);
        checkErr(err, 1'b0);
        word.word = raw;
    endtask

    // Each frame is the marker, MSB first, followed by LFSR payload bits.
    task automatic streamFrames(input int frames, input logic [31:0] mask,
                                input logic [31:0] marker, input logic checkOut);
        logic               hit;
        logic               bitNow;
        turboPkg::lockModeE pending;
        for (int f = 0; f < frames; f++) begin
            hit     = !mask[f];
            pending = modelMode;
            for (int j = 0; j < FRAME_BITS; j++) begin
                // The new state shows two bits after the marker completes.
                if (j == 33) begin
                    modelMode = pending;
                end
                if (j < 32) begin
                    bitNow = marker[31 - j] ^ (!hit && (j == 15));
                end else begin
                    bitNow = lfsr[0];
                    lfsr   = lfsrStep(lfsr);
                end
                bitIn    = bitNow;
                bitValid = 1'b1;
                if (checkOut && modelMode == turboPkg::LOCKED) begin
                    dueQ.push_back(cycleNo + 3);
                    expBitQ.push_back(bitNow);
                end
                if (j == 31) begin
                    case (modelMode)
                        turboPkg::SEARCH: begin
                            if (hit) begin
                                pending   = turboPkg::VERIFY;
                                modelMiss = 1'b0;
                            end
                        end
                        turboPkg::VERIFY: pending = hit ? turboPkg::LOCKED : turboPkg::SEARCH;
                        default: begin
                            if (hit) begin
                                modelMiss = 1'b0;
                            end else if (modelMiss) begin
                                pending = turboPkg::SEARCH;
                            end else begin
                                modelMiss = 1'b1;
                            end
                        end
                    endcase
                end
                @(posedge busClk);
                #2;
            end
        end
        bitValid = 1'b0;
    endtask

    // Syncs on two pulses so that the new divider is loaded, then checks one period.
    task automatic checkStrobe(input int div);
        int waited;
        for (int n = 0; n < 2; n++) begin
            waited = 0;
            do begin
                @(negedge busClk);
                waited++;
            end while (outputEn !== 1'b1 && waited < SYNC_LIMIT);
            if (outputEn !== 1'b1) begin
                $display("outputEn never pulsed within %0d cycles at %0t", SYNC_LIMIT, $time);
                noteResult(1'b0);
            end
        end
        for (int k = 1; k <= div + 1; k++) begin
            @(negedge busClk);
            checkBit("outputEn", outputEn, k == div + 1);
        end
        @(posedge busClk);
        #2;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command file handling.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic loadStimulus();
        int    fd;
        string line;
        fd = $fopen("bench/turboStimulus.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic int countCycles();
        int          total;
        string       op;
        logic [31:0] v0;
        total = 5 + MARGIN;
        foreach (lines[i]) begin
            v0 = 0;
            void'($sscanf(lines[i], "%s %h", op, v0));
            case (lines[i][0])
                "S":     total += v0 * FRAME_BITS + 4;
                "P":     total += 2 * SYNC_LIMIT + v0 + 4;
                default: total += 4;
            endcase
        end
        return total;
    endfunction

    task automatic closeTest();
        if (testName != "") begin
            if (testErrors == 0) begin
                testsPassed++;
                $display("test %s: ok", testName);
            end else begin
                testsFailed++;
                $display("test %s: %0d errors", testName, testErrors);
            end
        end
        testErrors = 0;
    endtask

    task automatic runCommands();
        string                 op;
        string                 name;
        logic [31:0]           v [10];
        logic [31:0]           rdata;
        logic                  err;
        turboPkg::regWordU     exp;
        turboPkg::regWordU     got;
        turboPkg::turboConfigS want;
        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s %h %h %h %h %h %h %h %h %h %h", op, v[0], v[1],
                          v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]));
            case (lines[i][0])
                "T": begin
                    closeTest();
                    void'($sscanf(lines[i], "%s %s", op, name));
                    testName = name;
                end
                "W": begin
                    apbTransfer(1'b1, v[0][12:0], v[1], v[2][3:0], rdata, err);
                    checkErr(err, v[3][0]);
                end
                "R": begin
                    apbTransfer(1'b0, v[0][12:0], 32'h0, 4'h0, rdata, err);
                    checkErr(err, v[2][0]);
                    exp.word = v[1];
                    checkWord("prdata", rdata, exp);
                end
                "S": streamFrames(v[0], v[1], v[2], v[3][0]);
                "L": begin
                    readControl(got);
                    checkLock(got.control.lockMode, turboPkg::lockModeE'(v[0][1:0]));
                end
                "O": begin
                    readControl(got);
                    checkBit("overflow", got.control.overflow, v[0][0]);
                end
                "P": checkStrobe(v[0]);
                "C": begin
                    want.codeRate            = v[0][2:0];
                    want.codeLength          = v[1][2:0];
                    want.maxIterations       = v[2][3:0];
                    want.inverseMeanMantissa = v[3][15:0];
                    want.inverseMeanExponent = v[4][2:0];
                    want.outputEnClkDiv      = v[5][15:0];
                    want.dac0Select          = v[6][3:0];
                    want.dac1Select          = v[7][3:0];
                    want.dac2Select          = v[8][3:0];
                    want.asmParms            = v[9];
                    checkConfig(turboConfig, want);
                end
                default: begin
                    $display("unknown command in stimulus file: %s", lines[i]);
                    noteResult(1'b0);
                end
            endcase
        end
    endtask

    initial begin
        int budget;
        busClk       = 1'b0;
        reset        = 1'b1;
        apbReq       = '0;
        bitIn        = 1'b0;
        bitValid     = 1'b0;
        cycleNo      = 0;
        checksPassed = 0;
        checksFailed = 0;
        testErrors   = 0;
        testsPassed  = 0;
        testsFailed  = 0;
        testName     = "";
        lfsr         = 32'hbce0;
        modelMode    = turboPkg::SEARCH;
        modelMiss    = 1'b0;
        loadStimulus();
        budget = countCycles();
        fork
            begin
                #(budget * CLK_PERIOD);
                $display("timeout after %0d cycles, the commands did not complete", budget);
                $display("** FAIL **");
                $finish;
            end
        join_none
        repeat (5) @(posedge busClk);
        #2;
        reset = 1'b0;
        if (lines.size() == 0) begin
            $display("stimulus file bench/turboStimulus.txt is missing or empty");
            $display("** FAIL **");
            $finish;
        end else begin
            runCommands();
            repeat (4) @(posedge busClk);   // Let the last monitored bits leave the pacer.
            closeTest();
            $display("tests: %0d passed, %0d failed; checks: %0d passed, %0d failed",
                     testsPassed, testsFailed, checksPassed, checksFailed);
            if (checksFailed == 0 && testsFailed == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule

// File: sources.f
rtl/turboPkg.sv
rtl/apbTurboSlave.sv
rtl/turboRegs.sv
rtl/asmSyncDetector.sv
rtl/outputBitPacer.sv
rtl/turboCtrlTop.sv
bench/turboCtrlTb.sv

// File: bench/turboStimulus.txt
# Hex fields: T name | W addr data strb err | R addr data err | L lockMode | O overflow
# S frames corruptMask marker checkOut | P divider | C rate len iter mant exp div d0 d1 d2 asm
T roundTrip
W 000 FFFFFFFF F 0
R 000 00000F77 0
W 004 FFFFFFFF F 0
R 004 0007FFFF 0
W 008 ABCD0012 F 0
R 008 00000012 0
W 00C FFFFFFFF F 0
R 00C 000F0F0F 0
W 010 1ACFFC1D F 0
R 010 1ACFFC1D 0
C 7 7 F FFFF 7 0012 F F F 1ACFFC1D
T byteLanes
W 000 00000000 2 0
R 000 00000077 0
W 000 00000023 1 0
R 000 00000023 0
W 004 00050000 4 0
R 004 0005FFFF 0
W 004 00001200 2 0
R 004 000512FF 0
W 00C 00000304 9 0
R 00C 000F0F04 0
W 010 00AA0000 4 0
R 010 1AAAFC1D 0
W 008 00000000 1 0
R 008 00000000 0
C 3 2 0 12FF 5 0000 4 F F 1AAAFC1D
T busErrors
W 002 FFFFFFFF F 1
W 014 FFFFFFFF F 1
W 1FFC FFFFFFFF F 1
R 001 00000000 1
R 018 00000000 1
R 000 00000023 0
R 004 000512FF 0
R 010 1AAAFC1D 0
C 3 2 0 12FF 5 0000 4 F F 1AAAFC1D
T syncAcquire
W 010 1ACFFC1D F 0
L 0
S 1 0 1ACFFC1D 1
L 1
S 1 0 1ACFFC1D 1
L 2
T pacedOutput
S 1 0 1ACFFC1D 1
L 2
W 008 00000004 3 0
P 4
W 008 00000000 3 0
P 0
T syncLoss
S 2 3 1ACFFC1D 1
L 0
T overflow
O 0
W 008 00000100 3 0
S 2 0 1ACFFC1D 0
L 2
O 1
W 000 00001000 2 0
O 0
R 000 00040023 0
